// ==== aes_dec_macros.svh ====
// sizes fixed for AES-256 decryption only; changing AES_ROUNDS alone does not give AES-128/192
`ifndef AES_DEC_MACROS_SVH
`define AES_DEC_MACROS_SVH

// inverse rounds after the initial key addition
`define AES_ROUNDS 14

// one block, bits
`define AES_BLOCK_W 128

// bytes per block, column-major
`define AES_BYTES 16

// round key index, 0 to AES_ROUNDS
`define AES_KEY_ADDR_W 4

`endif

// ==== aes_dec_pkg.sv ====
// types and GF(2^8) helpers for the AES-256 decryptor; the field functions are combinational only
`include "aes_dec_macros.svh"

package aes_dec_pkg;

    // one state byte
    typedef logic [7:0] aes_byte_t;

    // byte 4c+r is row r of column c
    typedef aes_byte_t [`AES_BYTES-1:0] aes_block_t;

    // round sequencer states
    typedef enum logic [3:0]
    {
        st_idle,
        st_add_key,
        st_inv_shift,
        st_sub_wait,
        st_mix,
        st_round_end,
        st_done
    } seq_state_t;

    // one datapath operation per cycle
    typedef enum logic [2:0]
    {
        cmd_none,
        cmd_load,
        cmd_inv_shift,
        cmd_add_key,
        cmd_inv_mix,
        cmd_emit
    } dp_cmd_t;

    // multiply by x, reduce by x^8+x^4+x^3+x+1
    function automatic aes_byte_t gf_mul2(input aes_byte_t a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    // shift-and-add product
    function automatic aes_byte_t gf_mul(input aes_byte_t a, input aes_byte_t b);
        aes_byte_t acc;
        aes_byte_t p;
        acc = 8'h00;
        p   = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                acc = acc ^ p;
            p = gf_mul2(p);
        end
        return acc;
    endfunction

    // inverse as a^254, so 0 maps to 0
    function automatic aes_byte_t gf_inv(input aes_byte_t a);
        aes_byte_t res;
        aes_byte_t base;
        res  = 8'h01;
        base = a;
        for (int i = 0; i < 8; i++)
        begin
            // exponent 254 = 8'b1111_1110
            if (i != 0)
                res = gf_mul(res, base);
            base = gf_mul(base, base);
        end
        return res;
    endfunction

endpackage

// ==== aes_dec_top.sv ====
// AES-256 single-block decryptor; caller supplies round keys combinationally, no back-pressure
`timescale 1ns/1ps
`include "aes_dec_macros.svh"

module aes_dec_top (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        in_valid,
    input  aes_dec_pkg::aes_block_t     data_in,
    input  aes_dec_pkg::aes_block_t     key,
    output logic [`AES_KEY_ADDR_W-1:0]  key_addr,
    output logic                        out_valid,
    output aes_dec_pkg::aes_block_t     data_out
);
    import aes_dec_pkg::*;

    dp_cmd_t    cmd;
    logic       sub_start;
    logic       sub_done;
    aes_block_t state_q;
    aes_block_t sub_block;

    // round control and key index
    aes_round_sequencer u_seq (
        .clk       (clk),
        .resetn    (resetn),
        .in_valid  (in_valid),
        .sub_done  (sub_done),
        .cmd       (cmd),
        .sub_start (sub_start),
        .key_addr  (key_addr),
        .out_valid (out_valid)
    );

    // serial byte substitution of the shifted state
    aes_inv_sub_bytes u_sub (
        .clk       (clk),
        .resetn    (resetn),
        .start     (sub_start),
        .block_in  (state_q),
        .block_out (sub_block),
        .done      (sub_done)
    );

    aes_round_datapath u_dp (
        .clk       (clk),
        .resetn    (resetn),
        .cmd       (cmd),
        .data_in   (data_in),
        .key       (key),
        .sub_block (sub_block),
        .sub_done  (sub_done),
        .state_q   (state_q),
        .data_out  (data_out)
    );

endmodule

// ==== aes_inv_sub_bytes.sv ====
// serial inverse S-box, one byte per cycle; start must not arrive while a block is in progress
`timescale 1ns/1ps
`include "aes_dec_macros.svh"

module aes_inv_sub_bytes (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    start,
    input  aes_dec_pkg::aes_block_t block_in,
    output aes_dec_pkg::aes_block_t block_out,
    output logic                    done
);
    import aes_dec_pkg::*;

    localparam int cnt_w = $clog2(`AES_BYTES);
    localparam logic [cnt_w-1:0] last_idx = cnt_w'(`AES_BYTES - 1);

    logic [`AES_BLOCK_W-1:0] sr;
    logic [cnt_w-1:0]        cnt;
    logic                    busy;
    aes_byte_t               sub_in;
    aes_byte_t               sub_out;

    // inverse affine map, rotations by 1, 3 and 6 plus 0x05
    function automatic aes_byte_t inv_affine(input aes_byte_t x);
        return {x[6:0], x[7]} ^ {x[4:0], x[7:5]} ^ {x[1:0], x[7:2]} ^ 8'h05;
    endfunction

    // byte 0 is substituted on the start cycle itself
    assign sub_in  = start ? block_in[0] : sr[7:0];
    assign sub_out = gf_inv(inv_affine(sub_in));

    // shift right one byte, new byte enters at the top
    // sixteen shifts bring the block back into order
    always_ff @(posedge clk)
    begin
        if (start)
            sr <= {sub_out, block_in[`AES_BYTES-1:1]};
        else if (busy)
            sr <= {sub_out, sr[`AES_BLOCK_W-1:8]};
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
            begin
                busy <= 1'b1;
                cnt  <= cnt_w'(1);
            end
            else if (busy)
            begin
                cnt <= cnt + 1'b1;
                if (cnt == last_idx)
                begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    assign block_out = sr;

    assert property (@(posedge clk) disable iff (!resetn)
        start |-> !busy);

endmodule

// ==== aes_round_datapath.sv ====
// AES state and result registers; commands come one per cycle and data_out is valid with out_valid
`timescale 1ns/1ps
`include "aes_dec_macros.svh"

module aes_round_datapath (
    input  logic                    clk,
    input  logic                    resetn,
    input  aes_dec_pkg::dp_cmd_t    cmd,
    input  aes_dec_pkg::aes_block_t data_in,
    input  aes_dec_pkg::aes_block_t key,
    input  aes_dec_pkg::aes_block_t sub_block,
    input  logic                    sub_done,
    output aes_dec_pkg::aes_block_t state_q,
    output aes_dec_pkg::aes_block_t data_out
);
    import aes_dec_pkg::*;

    localparam int num_cols = `AES_BYTES / 4;

    aes_block_t shift_blk;
    aes_block_t mix_blk;

    // inverse row shift
    // row r moves right by r columns
    always_comb
    begin
        for (int c = 0; c < num_cols; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                shift_blk[4*c+r] = state_q[4*((c - r + num_cols) % num_cols) + r];
            end
        end
    end

    // inverse column mixing
    // each row uses the circulant 0e 0b 0d 09
    always_comb
    begin
        for (int c = 0; c < num_cols; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                mix_blk[4*c+r] = gf_mul(state_q[4*c + r], 8'h0e)
                               ^ gf_mul(state_q[4*c + (r + 1) % 4], 8'h0b)
                               ^ gf_mul(state_q[4*c + (r + 2) % 4], 8'h0d)
                               ^ gf_mul(state_q[4*c + (r + 3) % 4], 8'h09);
            end
        end
    end

    // state register
    always_ff @(posedge clk)
    begin
        if (sub_done)
            state_q <= sub_block;
        else
        begin
            case (cmd)
                cmd_load:
                    state_q <= data_in;
                cmd_inv_shift:
                    state_q <= shift_blk;
                cmd_add_key:
                    state_q <= state_q ^ key;
                cmd_inv_mix:
                    state_q <= mix_blk;
                default:
                    state_q <= state_q;
            endcase
        end
    end

    // result register
    // holds the plaintext until the next emit
    always_ff @(posedge clk)
    begin
        if (cmd == cmd_emit)
            data_out <= state_q;
    end

    // sequencer must idle while substitution hands its block back
    assert property (@(posedge clk) disable iff (!resetn)
        sub_done |-> (cmd == cmd_none));

endmodule

// ==== aes_round_sequencer.sv ====
// round FSM for AES-256 decryption; in_valid is only taken in idle and key must follow key_addr
`timescale 1ns/1ps
`include "aes_dec_macros.svh"

module aes_round_sequencer (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        in_valid,
    input  logic                        sub_done,
    output aes_dec_pkg::dp_cmd_t        cmd,
    output logic                        sub_start,
    output logic [`AES_KEY_ADDR_W-1:0]  key_addr,
    output logic                        out_valid
);
    import aes_dec_pkg::*;

    localparam logic [`AES_KEY_ADDR_W-1:0] last_round = `AES_ROUNDS;

    seq_state_t                 state;
    seq_state_t                 state_next;
    logic [`AES_KEY_ADDR_W-1:0] round_q;

    // next state and the command for this cycle
    always_comb
    begin
        state_next = state;
        cmd        = cmd_none;
        case (state)
            st_idle:
            begin
                if (in_valid)
                begin
                    cmd        = cmd_load;
                    state_next = st_add_key;
                end
            end
            st_add_key:
            begin
                cmd = cmd_add_key;
                // round 0 is key addition only
                if (round_q == '0)
                    state_next = st_round_end;
                else if (round_q == last_round)
                    state_next = st_done;
                else
                    state_next = st_mix;
            end
            st_inv_shift:
            begin
                cmd        = cmd_inv_shift;
                state_next = st_sub_wait;
            end
            st_sub_wait:
            begin
                // datapath takes sub_block on this same pulse
                if (sub_done)
                    state_next = st_add_key;
            end
            st_mix:
            begin
                cmd        = cmd_inv_mix;
                state_next = st_round_end;
            end
            st_round_end:
                state_next = st_inv_shift;
            st_done:
            begin
                cmd        = cmd_emit;
                state_next = st_idle;
            end
            default:
                state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state     <= st_idle;
            round_q   <= '0;
            key_addr  <= last_round;
            sub_start <= 1'b0;
            out_valid <= 1'b0;
        end
        else
        begin
            state <= state_next;
            // substitution reads the shifted state one cycle later
            sub_start <= (state == st_inv_shift);
            out_valid <= (state == st_done);
            if (state == st_round_end)
            begin
                round_q  <= round_q + 1'b1;
                key_addr <= key_addr - 1'b1;
            end
            else if (state == st_done)
            begin
                // back to the first key for the next block
                round_q  <= '0;
                key_addr <= last_round;
            end
        end
    end

    // substitution hands back only while the FSM waits for it
    assert property (@(posedge clk) disable iff (!resetn)
        sub_done |-> (state == st_sub_wait));

    assert property (@(posedge clk) disable iff (!resetn)
        key_addr <= last_round);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the AES decryptor testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_aes_dec -f verilog.f -o tb_aes_dec
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_aes_dec > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides the result
if grep -qF '*** FAILED ***' "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi
exit 0

// ==== tb_aes_dec_model.svh ====
// reference decryption on caller round keys; include inside a module after round_keys is declared
`ifndef TB_AES_DEC_MODEL_SVH
`define TB_AES_DEC_MODEL_SVH

logic [7:0] fwd_sbox [0:255];
logic [7:0] inv_sbox [0:255];

// times x, reduced by the AES polynomial
function automatic logic [7:0] xtime(input logic [7:0] a);
    return (a << 1) ^ ({8{a[7]}} & 8'h1b);
endfunction

function automatic logic [7:0] field_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] acc;
    logic [7:0] p;
    acc = 8'h00;
    p   = a;
    for (int i = 0; i < 8; i++)
    begin
        acc = acc ^ ({8{b[i]}} & p);
        p   = xtime(p);
    end
    return acc;
endfunction

// powers of 3 walk every nonzero byte, q tracks the inverse
function automatic void build_sbox_tables();
    logic [7:0] p;
    logic [7:0] q;
    logic [7:0] x;
    p = 8'h01;
    q = 8'h01;
    for (int n = 0; n < 255; n++)
    begin
        p = p ^ xtime(p);
        // divide by 3
        q = q ^ (q << 1);
        q = q ^ (q << 2);
        q = q ^ (q << 4);
        if (q[7])
            q = q ^ 8'h09;
        // forward affine map
        x = q ^ {q[6:0], q[7]} ^ {q[5:0], q[7:6]} ^ {q[4:0], q[7:5]} ^ {q[3:0], q[7:4]};
        fwd_sbox[p] = x ^ 8'h63;
    end
    fwd_sbox[0] = 8'h63;
    for (int i = 0; i < 256; i++)
        inv_sbox[fwd_sbox[i]] = i[7:0];
endfunction

// row r of column c moves to column c+r
function automatic logic [127:0] unshift_rows(input logic [127:0] s);
    logic [127:0] t;
    for (int c = 0; c < 4; c++)
        for (int r = 0; r < 4; r++)
            t[8*(4*((c + r) % 4) + r) +: 8] = s[8*(4*c + r) +: 8];
    return t;
endfunction

function automatic logic [127:0] unsub_bytes(input logic [127:0] s);
    logic [127:0] t;
    for (int k = 0; k < 16; k++)
        t[8*k +: 8] = inv_sbox[s[8*k +: 8]];
    return t;
endfunction

// inverse mix matrix, row by row
function automatic logic [127:0] unmix_columns(input logic [127:0] s);
    logic [127:0] t;
    logic [7:0]   a [0:3];
    for (int c = 0; c < 4; c++)
    begin
        for (int r = 0; r < 4; r++)
            a[r] = s[8*(4*c + r) +: 8];
        t[8*(4*c)     +: 8] = field_mul(a[0], 8'h0e) ^ field_mul(a[1], 8'h0b)
                            ^ field_mul(a[2], 8'h0d) ^ field_mul(a[3], 8'h09);
        t[8*(4*c + 1) +: 8] = field_mul(a[0], 8'h09) ^ field_mul(a[1], 8'h0e)
                            ^ field_mul(a[2], 8'h0b) ^ field_mul(a[3], 8'h0d);
        t[8*(4*c + 2) +: 8] = field_mul(a[0], 8'h0d) ^ field_mul(a[1], 8'h09)
                            ^ field_mul(a[2], 8'h0e) ^ field_mul(a[3], 8'h0b);
        t[8*(4*c + 3) +: 8] = field_mul(a[0], 8'h0b) ^ field_mul(a[1], 8'h0d)
                            ^ field_mul(a[2], 8'h09) ^ field_mul(a[3], 8'h0e);
    end
    return t;
endfunction

// key 14 first, no column mixing after key 0
function automatic logic [127:0] decrypt_block(input logic [127:0] ct);
    logic [127:0] s;
    s = ct ^ round_keys[`AES_ROUNDS];
    for (int rnd = `AES_ROUNDS - 1; rnd >= 0; rnd--)
    begin
        s = unsub_bytes(unshift_rows(s)) ^ round_keys[rnd];
        if (rnd != 0)
            s = unmix_columns(s);
    end
    return s;
endfunction

`endif

// ==== tb_aes_dec.sv ====
// round keys are given directly, no key expansion; inputs change on falling edges only
`timescale 1ns/1ps
`include "aes_dec_macros.svh"

module tb_aes_dec;
    logic                       clk;
    logic                       resetn;
    logic                       in_valid;
    logic [`AES_BLOCK_W-1:0]    data_in;
    logic [`AES_BLOCK_W-1:0]    key;
    logic [`AES_KEY_ADDR_W-1:0] key_addr;
    logic                       out_valid;
    logic [`AES_BLOCK_W-1:0]    data_out;
    logic [`AES_BLOCK_W-1:0]    round_keys [0:`AES_ROUNDS];
    logic [`AES_BLOCK_W-1:0]    last_result;
    bit                         have_result;
    integer                     seed;
    int                         value_errors;
    int                         other_errors;
    int                         pulse_count;

    `include "tb_aes_dec_model.svh"

    aes_dec_top u_dut (
        .clk       (clk),
        .resetn    (resetn),
        .in_valid  (in_valid),
        .data_in   (data_in),
        .key       (key),
        .key_addr  (key_addr),
        .out_valid (out_valid),
        .data_out  (data_out)
    );

    always #2 clk = ~clk;

    // caller side key table lookup
    assign key = round_keys[key_addr];

    always @(posedge clk)
    begin
        if (out_valid)
            pulse_count++;
    end

    function automatic logic [127:0] random_block();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        assert (got === exp)
        else
        begin
            value_errors++;
            $display("[FAIL] %s: got %0h, expected %0h", name, got, exp);
        end
    endtask

    task automatic check_cond(input bit ok, input string msg);
        assert (ok)
        else
        begin
            other_errors++;
            $display("error: %s", msg);
        end
    endtask

    task automatic fill_keys(input bit zero);
        for (int i = 0; i <= `AES_ROUNDS; i++)
            round_keys[i] = zero ? '0 : random_block();
    endtask

    // one block, with optional extra strobes while busy
    task automatic run_block(input logic [127:0] ct, input bit with_extra);
        logic [127:0]               expected;
        logic [`AES_KEY_ADDR_W-1:0] prev_addr;
        int                         start_pulses;
        int                         n;
        bit                         seen;
        expected     = decrypt_block(ct);
        start_pulses = pulse_count;
        @(negedge clk);
        in_valid  = 1'b1;
        data_in   = ct;
        prev_addr = key_addr;
        seen      = 1'b0;
        n         = 0;
        while (!seen && n < 1000)
        begin
            @(negedge clk);
            in_valid = 1'b0;
            n++;
            if (out_valid)
            begin
                seen = 1'b1;
                check_value("data_out", data_out, expected);
                check_value("key_addr before out_valid", prev_addr, 0);
            end
            else
            begin
                check_cond(key_addr <= prev_addr,
                           $sformatf("key_addr rose from %0h to %0h", prev_addr, key_addr));
                // previous result must still be there
                if (have_result)
                    check_value("data_out", data_out, last_result);
                prev_addr = key_addr;
                if (with_extra && (n == 3 || n == 120 || n == 240))
                begin
                    in_valid = 1'b1;
                    data_in  = random_block();
                end
            end
        end
        check_cond(seen, "timed out waiting for out_valid");
        if (seen)
        begin
            // pulse drops, result stays
            for (int i = 0; i < 6; i++)
            begin
                @(negedge clk);
                check_value("out_valid", out_valid, 0);
                check_value("data_out", data_out, expected);
            end
            check_cond(pulse_count - start_pulses == 1, "out_valid count per block is not one");
            last_result = expected;
            have_result = 1'b1;
        end
    endtask

    // reset about a third of the way through a block
    task automatic reset_mid_run();
        @(negedge clk);
        in_valid = 1'b1;
        data_in  = random_block();
        @(negedge clk);
        in_valid = 1'b0;
        repeat (100) @(negedge clk);
        resetn = 1'b0;
        @(negedge clk);
        check_value("key_addr", key_addr, `AES_ROUNDS);
        repeat (2) @(negedge clk);
        resetn = 1'b1;
        // the aborted block never completes
        for (int i = 0; i < 400; i++)
        begin
            @(negedge clk);
            check_value("out_valid", out_valid, 0);
            if (have_result)
                check_value("data_out", data_out, last_result);
        end
    endtask

    initial
    begin
        clk          = 1'b0;
        resetn       = 1'b0;
        in_valid     = 1'b0;
        data_in      = '0;
        seed         = 32'hdcd12b8d;
        value_errors = 0;
        other_errors = 0;
        pulse_count  = 0;
        have_result  = 1'b0;
        last_result  = '0;
        fill_keys(1'b1);
        build_sbox_tables();
        // a few known table entries
        check_value("fwd_sbox[53]", fwd_sbox[8'h53], 8'hed);
        check_value("inv_sbox[63]", inv_sbox[8'h63], 8'h00);
        repeat (3) @(negedge clk);
        resetn = 1'b1;
        check_value("key_addr", key_addr, `AES_ROUNDS);
        check_value("out_valid", out_valid, 0);
        for (int b = 0; b < 20; b++)
        begin
            fill_keys(1'b0);
            run_block(random_block(), 1'b0);
        end
        // zero bytes take the 0 to 0 inverse
        fill_keys(1'b1);
        run_block('0, 1'b0);
        fill_keys(1'b0);
        run_block(random_block(), 1'b1);
        reset_mid_run();
        fill_keys(1'b0);
        run_block(random_block(), 1'b0);
        $display("summary: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors + other_errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+.
aes_dec_pkg.sv
aes_round_sequencer.sv
aes_inv_sub_bytes.sv
aes_round_datapath.sv
aes_dec_top.sv
tb_aes_dec.sv
